/* compile.f */
source/pipePkg.sv
source/stageReg.sv
source/dataMem.sv
source/loadExtend.sv
source/stageW.sv
source/regFile.sv
source/memWbTop.sv
tests/memWbTopTb.sv

/* run.sh */
#!/bin/sh
# Builds the memWbTop testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module memWbTopTb -o memWbTopTbSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "build failed with status $buildStatus"
    exit 1
fi

./obj_dir/memWbTopTbSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0

/* tests/memWbTopTb.sv */
// Testbench for the memory and write-back back end.
// Keeps byte memory and register models and checks every write-back against them.

`timescale 1ns/100ps

module memWbTopTb;
    import pipePkg::*;

    localparam int maxCycles = 1000;   // fill, random phase and both sweeps need about 870.

    typedef struct {
        int               due;         // cycle count at which the write-back shows.
        logic             regWEn;
        regAddrT          regWAddr;
        logic [wordW-1:0] data;
        logic [wordW-1:0] pc;
    } expectT;

    logic clk, rstN, inStrobe, regWEn, wbEn;
    instrT instr;
    ifuncT ifunc;
    regAddrT regWAddr, rdAddr, wbAddr;
    logic [wordW-1:0] pc, aluResult, addr, storeData, wbData, wbPc, rdData;

    logic [7:0]       memModel [memDepth*4];   // byte addressed.
    logic [wordW-1:0] regModel [32];
    expectT           expQ [$];
    logic [wordW-1:0] pcNext = '0;
    logic [wordW-1:0] lastAddr = '0;
    int               cycleCnt = 0;

    memWbTop DUT (
        .clk (clk), .rstN (rstN), .inStrobe (inStrobe), .instr (instr), .ifunc (ifunc),
        .pc (pc), .regWEn (regWEn), .regWAddr (regWAddr), .aluResult (aluResult),
        .addr (addr), .storeData (storeData), .rdAddr (rdAddr),
        .wbEn (wbEn), .wbAddr (wbAddr), .wbData (wbData), .wbPc (wbPc), .rdData (rdData)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt == maxCycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", maxCycles);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    task automatic reportMismatch(input string name, input logic [wordW-1:0] expVal,
                                  input logic [wordW-1:0] actVal);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                 $time, name, expVal, actVal);
        $display("ERRORS FOUND");
        $fatal(1, "check failed");
    endtask

    function automatic ifuncT classOf(input instrT op);
        case (op)
            LW, LH, LHU, LB, LBU: return I_MEM_R;
            SW, SH, SB:           return I_MEM_W;
            ADD, SUB, ORI:        return I_ALU;
            default:              return I_NONE;
        endcase
    endfunction

    // the halfword sits on address bit 1, the byte on both low bits.
    function automatic logic [wordW-1:0] loadModel(input instrT op, input logic [wordW-1:0] a);
        logic [memAddrW-1:0] w;
        logic [15:0]         half;
        logic [7:0]          byteVal;
        w       = a[memAddrW+1:2];
        half    = {memModel[{w, a[1], 1'b1}], memModel[{w, a[1], 1'b0}]};
        byteVal = memModel[{w, a[1:0]}];
        case (op)
            LH:      return {{16{half[15]}}, half};
            LHU:     return {16'h0000, half};
            LB:      return {{24{byteVal[7]}}, byteVal};
            LBU:     return {24'h000000, byteVal};
            default: return {memModel[{w, 2'd3}], memModel[{w, 2'd2}],
                             memModel[{w, 2'd1}], memModel[{w, 2'd0}]};
        endcase
    endfunction

    task automatic storeModel(input instrT op, input logic [wordW-1:0] a,
                              input logic [wordW-1:0] d);
        logic [memAddrW-1:0] w;
        w = a[memAddrW+1:2];
        case (op)
            SW: {memModel[{w, 2'd3}], memModel[{w, 2'd2}],
                 memModel[{w, 2'd1}], memModel[{w, 2'd0}]} = d;
            SH: {memModel[{w, a[1], 1'b1}], memModel[{w, a[1], 1'b0}]} = d[15:0];
            default: memModel[{w, a[1:0]}] = d[7:0];
        endcase
    endtask

    task automatic driveIdle();
        inStrobe <= 1'b0;
    endtask

    // drives one instruction and books its write-back three counts later.
    task automatic issue(input instrT op, input regAddrT rd, input logic [wordW-1:0] alu,
                         input logic [wordW-1:0] a, input logic [wordW-1:0] sd);
        expectT e;
        logic   wen;
        wen = (classOf(op) == I_MEM_R) || (classOf(op) == I_ALU);
        inStrobe  <= 1'b1;
        instr     <= op;
        ifunc     <= classOf(op);
        pc        <= pcNext;
        regWEn    <= wen;
        regWAddr  <= rd;
        aluResult <= alu;
        addr      <= a;
        storeData <= sd;
        e.due      = cycleCnt + 3;
        e.regWEn   = wen;
        e.regWAddr = rd;
        e.pc       = pcNext;
        e.data     = (classOf(op) == I_MEM_R) ? loadModel(op, a) : alu;
        if (classOf(op) == I_MEM_W)
            storeModel(op, a, sd);   // stores land before the next load reads.
        if (wen && (rd != '0))
            regModel[rd] = e.data;
        expQ.push_back(e);
        pcNext   = pcNext + 4;
        lastAddr = a;
    endtask

    task automatic sweepRegs();
        for (int r = 0; r < 32; r++)
        begin
            @(posedge clk);
            rdAddr <= r[4:0];
            @(negedge clk);
            assert (rdData === regModel[r[4:0]])
                else reportMismatch($sformatf("rdData[%0d]", r), regModel[r[4:0]], rdData);
        end
    endtask

    assert property (@(negedge clk) !rstN |-> !wbEn)
        else reportMismatch("wbEn", '0, 32'(wbEn));
    assert property (@(negedge clk) (rdAddr == '0) |-> (rdData == '0))
        else reportMismatch("rdData", '0, rdData);

    // outputs are stable at the falling edge.
    always @(negedge clk)
    begin
        expectT e;
        if ((expQ.size() != 0) && (expQ[0].due == cycleCnt))
        begin
            e = expQ.pop_front();
            assert (wbEn === e.regWEn) else reportMismatch("wbEn", 32'(e.regWEn), 32'(wbEn));
            assert (wbAddr === e.regWAddr)
                else reportMismatch("wbAddr", 32'(e.regWAddr), 32'(wbAddr));
            assert (wbPc === e.pc) else reportMismatch("wbPc", e.pc, wbPc);
            assert (wbData === e.data) else reportMismatch("wbData", e.data, wbData);
        end
        else
        begin
            assert (wbEn === 1'b0) else reportMismatch("wbEn", '0, 32'(wbEn));
        end
    end

    initial
    begin
        int               issued;
        logic [wordW-1:0] a;
        logic [3:0]       opIdx;
        void'($urandom(32'he76e_475d));
        for (int r = 0; r < 32; r++)
            regModel[r] = '0;
        rstN      <= 1'b0;
        inStrobe  <= 1'b0;
        instr     <= NOP;
        ifunc     <= I_NONE;
        pc        <= '0;
        regWEn    <= 1'b0;
        regWAddr  <= '0;
        aluResult <= '0;
        addr      <= '0;
        storeData <= '0;
        rdAddr    <= '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        sweepRegs();

        // every word gets a defined value before any load.
        for (int w = 0; w < memDepth; w++)
        begin
            @(posedge clk);
            a = w * 4;
            issue(SW, 5'($urandom_range(0, 31)), $urandom, a, $urandom);
        end

        issued = 0;
        while (issued < 400)
        begin
            @(posedge clk);
            if ($urandom_range(0, 3) == 0)
            begin
                driveIdle();
            end
            else
            begin
                opIdx = 4'($urandom_range(0, 11));
                if ($urandom_range(0, 3) == 0)
                    a = {lastAddr[wordW-1:2], 2'($urandom_range(0, 3))};   // same word again.
                else
                    a = $urandom_range(0, memDepth * 4 - 1);
                issue(instrT'(opIdx), 5'($urandom_range(0, 31)), $urandom, a, $urandom);
                issued++;
            end
        end

        @(posedge clk);
        driveIdle();
        while (expQ.size() != 0)
            @(posedge clk);
        sweepRegs();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* source/memWbTop.sv */
// Back end of the pipeline.
// Joins the two stage registers, data memory, write-back stage and register file.

`timescale 1ns/100ps

module memWbTop (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inStrobe,
    input  pipePkg::instrT             instr,
    input  pipePkg::ifuncT             ifunc,
    input  logic [pipePkg::wordW-1:0]  pc,
    input  logic                       regWEn,
    input  pipePkg::regAddrT           regWAddr,
    input  logic [pipePkg::wordW-1:0]  aluResult,
    input  logic [pipePkg::wordW-1:0]  addr,
    input  logic [pipePkg::wordW-1:0]  storeData,
    input  pipePkg::regAddrT           rdAddr,
    output logic                       wbEn,
    output pipePkg::regAddrT           wbAddr,
    output logic [pipePkg::wordW-1:0]  wbData,
    output logic [pipePkg::wordW-1:0]  wbPc,
    output logic [pipePkg::wordW-1:0]  rdData
);
    import pipePkg::*;

    memStageT         emIn, emData;
    wbStageT          mwIn, mwData;
    logic             emValid, mwValid;
    logic [wordW-1:0] readWord;

    assign emIn = '{instr: instr, ifunc: ifunc, pc: pc, regWEn: regWEn, regWAddr: regWAddr,
                    regWData: aluResult, addr: addr, storeData: storeData};

    // the memory stage keeps only the byte offset of the address.
    assign mwIn = '{instr: emData.instr, ifunc: emData.ifunc, pc: emData.pc,
                    regWEn: emData.regWEn, regWAddr: emData.regWAddr,
                    regWData: emData.regWData, offset: emData.addr[1:0]};

    stageReg #(.payloadT(memStageT)) emReg (
        .clk (clk), .rstN (rstN),
        .inValid (inStrobe), .inData (emIn),
        .outValid (emValid), .outData (emData)
    );

    dataMem dMem (
        .clk       (clk),
        .addr      (emData.addr),
        .instr     (emData.instr),
        .storeData (emData.storeData),
        .writeReq  (emValid && (emData.ifunc == I_MEM_W)),
        .readWord  (readWord)
    );

    stageReg #(.payloadT(wbStageT)) mwReg (
        .clk (clk), .rstN (rstN),
        .inValid (emValid), .inData (mwIn),
        .outValid (mwValid), .outData (mwData)
    );

    stageW wbStage (
        .wbValid (mwValid), .instr (mwData.instr), .ifunc (mwData.ifunc), .pc (mwData.pc),
        .regWEn (mwData.regWEn), .regWAddr (mwData.regWAddr), .regWData (mwData.regWData),
        .offset (mwData.offset), .memWord (readWord),
        .wbEn (wbEn), .wbAddr (wbAddr), .wbData (wbData), .wbPc (wbPc)
    );

    regFile grf (
        .clk (clk), .rstN (rstN),
        .wrEn (wbEn), .wrAddr (wbAddr), .wrData (wbData),
        .rdAddr (rdAddr), .rdData (rdData)
    );

endmodule

/* source/regFile.sv */
// General register file.
// One synchronous write port and one asynchronous read port; register 0 stays zero.

`timescale 1ns/100ps

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       wrEn,
    input  pipePkg::regAddrT           wrAddr,
    input  logic [pipePkg::wordW-1:0]  wrData,
    input  pipePkg::regAddrT           rdAddr,
    output logic [pipePkg::wordW-1:0]  rdData
);
    import pipePkg::*;

    logic [wordW-1:0] regs [2**$bits(regAddrT)];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 2**$bits(regAddrT); i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && (wrAddr != '0))
        begin
            regs[wrAddr] <= wrData;   // writes to register 0 are dropped.
        end
    end

    // reads see the stored contents without waiting for a clock.
    assign rdData = regs[rdAddr];

endmodule

/* source/stageW.sv */
// Write-back stage.
// Chooses between load data and the carried ALU result and drives the GRF write port.

`timescale 1ns/100ps

module stageW (
    input  logic                       wbValid,
    input  pipePkg::instrT             instr,
    input  pipePkg::ifuncT             ifunc,
    input  logic [pipePkg::wordW-1:0]  pc,
    input  logic                       regWEn,
    input  pipePkg::regAddrT           regWAddr,
    input  logic [pipePkg::wordW-1:0]  regWData,
    input  logic [1:0]                 offset,
    input  logic [pipePkg::wordW-1:0]  memWord,
    output logic                       wbEn,
    output pipePkg::regAddrT           wbAddr,
    output logic [pipePkg::wordW-1:0]  wbData,
    output logic [pipePkg::wordW-1:0]  wbPc
);
    import pipePkg::*;

    logic [wordW-1:0] extWord;

    loadExtend loadExt (
        .memWord (memWord),
        .offset  (offset),
        .instr   (instr),
        .extWord (extWord)
    );

    // a bubble must never write, even with a stale payload behind it.
    assign wbEn   = regWEn && wbValid;
    assign wbAddr = regWAddr;
    assign wbPc   = pc;

    // loads return memory data, every other class its carried result.
    assign wbData = (ifunc == I_MEM_R) ? extWord : regWData;

endmodule

/* source/loadExtend.sv */
// Load data extension.
// Picks the byte or halfword of a loaded word and zero- or sign-extends it.

`timescale 1ns/100ps

module loadExtend (
    input  logic [pipePkg::wordW-1:0]  memWord,
    input  logic [1:0]                 offset,
    input  pipePkg::instrT             instr,
    output logic [pipePkg::wordW-1:0]  extWord
);
    import pipePkg::*;

    logic [15:0] halfVal;
    logic [7:0]  byteVal;
    logic        signExt;

    // halfwords sit on bit 1 of the offset, bytes on the whole offset.
    assign halfVal = memWord[offset[1]*16 +: 16];
    assign byteVal = memWord[offset*8 +: 8];

    // only the unsigned loads fill with zeros.
    assign signExt = (instr == LH) || (instr == LB);

    always_comb
    begin
        case (instr)
            LH, LHU:
            begin
                extWord = {{(wordW-16){signExt & halfVal[15]}}, halfVal};
            end
            LB, LBU:
            begin
                extWord = {{(wordW-8){signExt & byteVal[7]}}, byteVal};
            end
            default:
            begin
                extWord = memWord;   // LW and anything else take the full word.
            end
        endcase
    end

endmodule

/* source/dataMem.sv */
// Data memory of the memory stage.
// Aligns store data to its byte lanes and reads one full word per cycle.

`timescale 1ns/100ps

module dataMem (
    input  logic                       clk,
    input  logic [pipePkg::wordW-1:0]  addr,
    input  pipePkg::instrT             instr,
    input  logic [pipePkg::wordW-1:0]  storeData,
    input  logic                       writeReq,
    output logic [pipePkg::wordW-1:0]  readWord
);
    import pipePkg::*;

    logic [wordW-1:0]    mem [memDepth];
    logic [memAddrW-1:0] wordAddr;
    logic [3:0]          byteEn;
    logic [wordW-1:0]    laneData;

    assign wordAddr = addr[memAddrW+1:2];   // the low two bits select lanes.

    // store data is replicated so every lane sees its own copy.
    always_comb
    begin
        byteEn   = 4'b0000;
        laneData = storeData;
        case (instr)
            SW:
            begin
                byteEn = 4'b1111;
            end
            SH:
            begin
                byteEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{storeData[15:0]}};
            end
            SB:
            begin
                byteEn   = 4'b0001 << addr[1:0];
                laneData = {4{storeData[7:0]}};
            end
            default:
            begin
                byteEn = 4'b0000;   // loads and ALU ops never write.
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (writeReq)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byteEn[i])
                begin
                    mem[wordAddr][i*8 +: 8] <= laneData[i*8 +: 8];
                end
            end
        end
        // a store in the same cycle is not yet visible here.
        readWord <= mem[wordAddr];
    end

endmodule

/* source/stageReg.sv */
// Pipeline boundary register.
// Holds one stage payload of any packed type together with its valid bit.

`timescale 1ns/100ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // the valid bit follows the strobe, so a gap leaves a bubble behind.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
        end
        else
        begin
            outValid <= inValid;
        end
    end

    // payload only moves when a real instruction arrives.
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            outData <= inData;   // keeps the last instruction during bubbles.
        end
    end

endmodule

/* source/pipePkg.sv */
// Shared definitions for the memory and write-back end of the pipeline.
// Holds widths, instruction codes, function classes and the stage payloads.

package pipePkg;

    localparam int wordW    = 32;
    localparam int memDepth = 256;                 // data memory size in words.
    localparam int memAddrW = $clog2(memDepth);

    // instructions that reach the memory and write-back stages.
    typedef enum logic [3:0] {
        LW, LH, LHU, LB, LBU,
        SW, SH, SB,
        ADD, SUB, ORI,
        NOP
    } instrT;

    // coarse class of an instruction, decoded once in the front end.
    typedef enum logic [1:0] {
        I_ALU, I_MEM_R, I_MEM_W, I_NONE
    } ifuncT;

    typedef logic [4:0] regAddrT;

    // latched at the execute/memory boundary.
    typedef struct packed {
        instrT              instr;
        ifuncT              ifunc;
        logic [wordW-1:0]   pc;
        logic               regWEn;
        regAddrT            regWAddr;
        logic [wordW-1:0]   regWData;      // the ALU result.
        logic [wordW-1:0]   addr;          // byte address for loads and stores.
        logic [wordW-1:0]   storeData;
    } memStageT;

    // latched at the memory/write-back boundary.
    typedef struct packed {
        instrT              instr;
        ifuncT              ifunc;
        logic [wordW-1:0]   pc;
        logic               regWEn;
        regAddrT            regWAddr;
        logic [wordW-1:0]   regWData;
        logic [1:0]         offset;        // byte offset of the access within its word.
    } wbStageT;

endpackage
